// File: hdl/core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int XLEN    = 64;
    localparam int IMM_W   = 32;
    localparam int SHAMT_W = 6;

    // register file
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;

    // issue queue depth is also the sender's starting credit count
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

endpackage

// File: hdl/isa_pkg.sv
package isa_pkg;

    // the top opcode bit selects the logic pipe
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_SLT  = 3'd2,
        OP_SLTU = 3'd3,
        OP_AND  = 3'd4,
        OP_OR   = 3'd5,
        OP_XOR  = 3'd6,
        OP_SLL  = 3'd7
    } op_e;

    typedef enum logic {
        PIPE_ARITH = 1'b0,
        PIPE_LOGIC = 1'b1
    } pipe_e;

    // pipe that executes a given opcode
    function automatic pipe_e op_pipe(input op_e op);
        return op[2] ? PIPE_LOGIC : PIPE_ARITH;
    endfunction

endpackage

// File: hdl/core_ifs.sv
`timescale 1ns/1ns

// one instruction handed from the issue control to a pipe
interface issue_if;
    logic                            valid;
    isa_pkg::op_e                    op;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [core_pkg::IMM_W-1:0]      imm;
    logic                            use_imm;

    modport issue (output valid, op, rd, imm, use_imm);
    modport pipe (input valid, op, rd, imm, use_imm);
endinterface

// four read ports, data returns one clock after the address
interface rf_read_if;
    logic [core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs3_addr;
    logic [core_pkg::REG_ADDR_W-1:0] rs4_addr;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;
    logic [core_pkg::XLEN-1:0]       rs3_data;
    logic [core_pkg::XLEN-1:0]       rs4_data;

    modport issue (output rs1_addr, rs2_addr, rs3_addr, rs4_addr);
    modport regfile (
        input  rs1_addr, rs2_addr, rs3_addr, rs4_addr,
        output rs1_data, rs2_data, rs3_data, rs4_data
    );
    // ports 1 and 2 feed the arithmetic pipe
    modport arith (input rs1_data, rs2_data);
    // ports 3 and 4 feed the logic pipe
    modport xlogic (input rs3_data, rs4_data);
endinterface

// File: hdl/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_inst_valid,
    input  isa_pkg::op_e                    i_inst_op,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_inst_rd,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_inst_rs1,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_inst_rs2,
    input  logic [core_pkg::IMM_W-1:0]      i_inst_imm,
    input  logic                            i_inst_use_imm,
    output logic                            o_credit,
    output logic                            o_credit_two,
    issue_if.issue                          o_arith,
    issue_if.issue                          o_logic,
    rf_read_if.issue                        rf,
    input  logic                            i_arith_wb_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_arith_wb_rd,
    input  logic                            i_logic_wb_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_logic_wb_rd
);

    typedef logic [core_pkg::QPTR_W-1:0]   qptr_t;
    typedef logic [core_pkg::QCNT_W-1:0]   cnt_t;
    typedef logic [core_pkg::NUM_REGS-1:0] regmask_t;

    typedef struct packed {
        isa_pkg::op_e                    op;
        logic [core_pkg::REG_ADDR_W-1:0] rd;
        logic [core_pkg::REG_ADDR_W-1:0] rs1;
        logic [core_pkg::REG_ADDR_W-1:0] rs2;
        logic [core_pkg::IMM_W-1:0]      imm;
        logic                            use_imm;
    } entry_t;

    entry_t          queue [core_pkg::QUEUE_DEPTH];
    qptr_t           q_head;
    qptr_t           q_tail;
    cnt_t            q_count;
    regmask_t        busy;
    regmask_t        busy_clr;
    regmask_t        busy_set;
    regmask_t        busy_eff;
    entry_t          first;
    entry_t          second;
    isa_pkg::pipe_e  first_pipe;
    isa_pkg::pipe_e  second_pipe;
    logic            issue_first;
    logic            issue_second;
    logic [1:0]      num_issued;
    entry_t          arith_e;
    entry_t          logic_e;

    // entry touches a register whose result is still pending
    function automatic logic hazard(input entry_t e, input regmask_t pend);
        return pend[e.rs1] || (!e.use_imm && pend[e.rs2]) || pend[e.rd];
    endfunction

    // younger entry reads or overwrites what the older one produces
    function automatic logic depends(input entry_t younger, input entry_t older);
        logic hit;
        hit = (younger.rs1 == older.rd) || (younger.rd == older.rd)
            || (!younger.use_imm && (younger.rs2 == older.rd));
        return hit && (older.rd != '0);
    endfunction

    assign first       = queue[q_head];
    assign second      = queue[q_head + qptr_t'(1)];
    assign q_tail      = q_head + qptr_t'(q_count);
    assign first_pipe  = isa_pkg::op_pipe(first.op);
    assign second_pipe = isa_pkg::op_pipe(second.op);

    // writebacks this cycle release their registers right away,
    // the register file forwards the data at the same edge
    always_comb begin
        busy_clr = '0;
        if (i_arith_wb_valid) begin
            busy_clr[i_arith_wb_rd] = 1'b1;
        end
        if (i_logic_wb_valid) begin
            busy_clr[i_logic_wb_rd] = 1'b1;
        end
    end

    assign busy_eff = busy & ~busy_clr;

    // in-order dual issue, the second entry only goes to the other pipe
    assign issue_first  = (q_count != '0) && !hazard(first, busy_eff);
    assign issue_second = issue_first && (q_count > cnt_t'(1))
                        && (second_pipe != first_pipe)
                        && !depends(second, first)
                        && !hazard(second, busy_eff);
    assign num_issued   = {1'b0, issue_first} + {1'b0, issue_second};

    always_comb begin
        busy_set = '0;
        if (issue_first) begin
            busy_set[first.rd] = 1'b1;
        end
        if (issue_second) begin
            busy_set[second.rd] = 1'b1;
        end
        // x0 is never pending
        busy_set[0] = 1'b0;
    end

    // steering
    assign arith_e = (first_pipe == isa_pkg::PIPE_ARITH) ? first : second;
    assign logic_e = (first_pipe == isa_pkg::PIPE_LOGIC) ? first : second;

    assign o_arith.valid   = issue_first && ((first_pipe == isa_pkg::PIPE_ARITH) || issue_second);
    assign o_arith.op      = arith_e.op;
    assign o_arith.rd      = arith_e.rd;
    assign o_arith.imm     = arith_e.imm;
    assign o_arith.use_imm = arith_e.use_imm;

    assign o_logic.valid   = issue_first && ((first_pipe == isa_pkg::PIPE_LOGIC) || issue_second);
    assign o_logic.op      = logic_e.op;
    assign o_logic.rd      = logic_e.rd;
    assign o_logic.imm     = logic_e.imm;
    assign o_logic.use_imm = logic_e.use_imm;

    assign rf.rs1_addr = arith_e.rs1;
    assign rf.rs2_addr = arith_e.rs2;
    assign rf.rs3_addr = logic_e.rs1;
    assign rf.rs4_addr = logic_e.rs2;

    // one credit back per issued entry
    assign o_credit     = issue_first;
    assign o_credit_two = issue_second;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            q_head  <= '0;
            q_count <= '0;
            busy    <= '0;
        end else begin
            q_head  <= q_head + qptr_t'(num_issued);
            q_count <= q_count + cnt_t'(i_inst_valid) - cnt_t'(num_issued);
            busy    <= busy_eff | busy_set;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_inst_valid) begin
            queue[q_tail] <= '{
                op:      i_inst_op,
                rd:      i_inst_rd,
                rs1:     i_inst_rs1,
                rs2:     i_inst_rs2,
                imm:     i_inst_imm,
                use_imm: i_inst_use_imm
            };
        end
    end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    rf_read_if.regfile                      rf,
    input  logic                            i_wr1_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_wr1_rd,
    input  logic [core_pkg::XLEN-1:0]       i_wr1_data,
    input  logic                            i_wr2_valid,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_wr2_rd,
    input  logic [core_pkg::XLEN-1:0]       i_wr2_data
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

    // x0 reads zero, a write at the same edge wins over the stored value
    function automatic logic [core_pkg::XLEN-1:0] read_port(
        input logic [core_pkg::REG_ADDR_W-1:0] addr
    );
        logic [core_pkg::XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (i_wr2_valid && (i_wr2_rd == addr)) begin
            data = i_wr2_data;
        end else if (i_wr1_valid && (i_wr1_rd == addr)) begin
            data = i_wr1_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            rf.rs1_data <= '0;
            rf.rs2_data <= '0;
            rf.rs3_data <= '0;
            rf.rs4_data <= '0;
        end else begin
            if (i_wr1_valid && (i_wr1_rd != '0)) begin
                regs[i_wr1_rd] <= i_wr1_data;
            end
            if (i_wr2_valid && (i_wr2_rd != '0)) begin
                regs[i_wr2_rd] <= i_wr2_data;
            end
            rf.rs1_data <= read_port(rf.rs1_addr);
            rf.rs2_data <= read_port(rf.rs2_addr);
            rf.rs3_data <= read_port(rf.rs3_addr);
            rf.rs4_data <= read_port(rf.rs4_addr);
        end
    end

endmodule

// File: hdl/arith_unit.sv
`timescale 1ns/1ns

module arith_unit (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    issue_if.pipe                           iss,
    rf_read_if.arith                        rf,
    output logic                            o_wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [core_pkg::XLEN-1:0]       o_wb_data
);

    logic                            s1_valid;
    isa_pkg::op_e                    s1_op;
    logic [core_pkg::REG_ADDR_W-1:0] s1_rd;
    logic [core_pkg::IMM_W-1:0]      s1_imm;
    logic                            s1_use_imm;
    logic [core_pkg::XLEN-1:0]       imm_ext;
    logic [core_pkg::XLEN-1:0]       op_a;
    logic [core_pkg::XLEN-1:0]       op_b;
    logic [core_pkg::XLEN-1:0]       result;

    // hold the issue fields until the operands come back
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= iss.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_op      <= iss.op;
        s1_rd      <= iss.rd;
        s1_imm     <= iss.imm;
        s1_use_imm <= iss.use_imm;
    end

    assign imm_ext = {{(core_pkg::XLEN - core_pkg::IMM_W){s1_imm[core_pkg::IMM_W-1]}}, s1_imm};
    assign op_a    = rf.rs1_data;
    assign op_b    = s1_use_imm ? imm_ext : rf.rs2_data;

    always_comb begin
        case (s1_op)
            isa_pkg::OP_SUB:  result = op_a - op_b;
            isa_pkg::OP_SLT:  result = {{(core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            isa_pkg::OP_SLTU: result = {{(core_pkg::XLEN-1){1'b0}}, op_a < op_b};
            default:          result = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= s1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd   <= s1_rd;
        o_wb_data <= result;
    end

endmodule

// File: hdl/logic_unit.sv
`timescale 1ns/1ns

module logic_unit (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    issue_if.pipe                           iss,
    rf_read_if.xlogic                       rf,
    output logic                            o_wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [core_pkg::XLEN-1:0]       o_wb_data
);

    logic                            s1_valid;
    isa_pkg::op_e                    s1_op;
    logic [core_pkg::REG_ADDR_W-1:0] s1_rd;
    logic [core_pkg::IMM_W-1:0]      s1_imm;
    logic                            s1_use_imm;
    logic [core_pkg::XLEN-1:0]       imm_ext;
    logic [core_pkg::XLEN-1:0]       op_a;
    logic [core_pkg::XLEN-1:0]       op_b;
    logic [core_pkg::XLEN-1:0]       result;

    // line up the issue fields with the operand data
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= iss.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        s1_op      <= iss.op;
        s1_rd      <= iss.rd;
        s1_imm     <= iss.imm;
        s1_use_imm <= iss.use_imm;
    end

    assign imm_ext = {{(core_pkg::XLEN - core_pkg::IMM_W){s1_imm[core_pkg::IMM_W-1]}}, s1_imm};
    assign op_a    = rf.rs3_data;
    assign op_b    = s1_use_imm ? imm_ext : rf.rs4_data;

    always_comb begin
        case (s1_op)
            isa_pkg::OP_AND: result = op_a & op_b;
            isa_pkg::OP_OR:  result = op_a | op_b;
            isa_pkg::OP_XOR: result = op_a ^ op_b;
            // shift amount is the low six bits only
            default:         result = op_a << op_b[core_pkg::SHAMT_W-1:0];
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= s1_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd   <= s1_rd;
        o_wb_data <= result;
    end

endmodule

// File: hdl/exec_core.sv
`timescale 1ns/1ns

module exec_core (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_inst_valid,
    input  isa_pkg::op_e                    i_inst_op,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_inst_rd,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_inst_rs1,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_inst_rs2,
    input  logic [core_pkg::IMM_W-1:0]      i_inst_imm,
    input  logic                            i_inst_use_imm,
    output logic                            o_credit,
    output logic                            o_credit_two,
    output logic                            o_arith_wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] o_arith_wb_rd,
    output logic [core_pkg::XLEN-1:0]       o_arith_wb_data,
    output logic                            o_logic_wb_valid,
    output logic [core_pkg::REG_ADDR_W-1:0] o_logic_wb_rd,
    output logic [core_pkg::XLEN-1:0]       o_logic_wb_data
);

    issue_if   arith_iss ();
    issue_if   logic_iss ();
    rf_read_if rf_rd ();

    issue_ctrl issue_ctrl_inst (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_inst_valid     (i_inst_valid),
        .i_inst_op        (i_inst_op),
        .i_inst_rd        (i_inst_rd),
        .i_inst_rs1       (i_inst_rs1),
        .i_inst_rs2       (i_inst_rs2),
        .i_inst_imm       (i_inst_imm),
        .i_inst_use_imm   (i_inst_use_imm),
        .o_credit         (o_credit),
        .o_credit_two     (o_credit_two),
        .o_arith          (arith_iss.issue),
        .o_logic          (logic_iss.issue),
        .rf               (rf_rd.issue),
        .i_arith_wb_valid (o_arith_wb_valid),
        .i_arith_wb_rd    (o_arith_wb_rd),
        .i_logic_wb_valid (o_logic_wb_valid),
        .i_logic_wb_rd    (o_logic_wb_rd)
    );

    // write port 1 takes the arithmetic pipe, port 2 the logic pipe
    reg_file reg_file_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .rf          (rf_rd.regfile),
        .i_wr1_valid (o_arith_wb_valid),
        .i_wr1_rd    (o_arith_wb_rd),
        .i_wr1_data  (o_arith_wb_data),
        .i_wr2_valid (o_logic_wb_valid),
        .i_wr2_rd    (o_logic_wb_rd),
        .i_wr2_data  (o_logic_wb_data)
    );

    arith_unit arith_unit_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .iss        (arith_iss.pipe),
        .rf         (rf_rd.arith),
        .o_wb_valid (o_arith_wb_valid),
        .o_wb_rd    (o_arith_wb_rd),
        .o_wb_data  (o_arith_wb_data)
    );

    logic_unit logic_unit_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .iss        (logic_iss.pipe),
        .rf         (rf_rd.xlogic),
        .o_wb_valid (o_logic_wb_valid),
        .o_wb_rd    (o_logic_wb_rd),
        .o_wb_data  (o_logic_wb_data)
    );

endmodule

// File: verif/exec_core_sva.sv
`timescale 1ns/1ns

module exec_core_sva (
    input logic                          i_clk,
    input logic                          i_rst_n,
    input logic [core_pkg::QCNT_W-1:0]   i_q_count,
    input logic                          i_credit,
    input logic                          i_credit_two,
    input logic                          i_arith_issue,
    input logic                          i_logic_issue,
    input logic [core_pkg::NUM_REGS-1:0] i_busy_set,
    input logic [core_pkg::NUM_REGS-1:0] i_busy_eff
);

    // queue never holds more than its depth
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        int'(i_q_count) <= core_pkg::QUEUE_DEPTH)
        else $error("issue queue holds %0d entries", i_q_count);

    // each credit handed back matches one entry sent to a pipe
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (int'(i_credit) + int'(i_credit_two))
            == (int'(i_arith_issue) + int'(i_logic_issue)))
        else $error("credits returned do not match the number of issues");

    // issued destinations must not still be pending
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_busy_set & i_busy_eff) == '0)
        else $error("issue to a busy destination, mask %h", i_busy_set & i_busy_eff);

endmodule

bind issue_ctrl exec_core_sva exec_core_sva_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_q_count     (q_count),
    .i_credit      (o_credit),
    .i_credit_two  (o_credit_two),
    .i_arith_issue (o_arith.valid),
    .i_logic_issue (o_logic.valid),
    .i_busy_set    (busy_set),
    .i_busy_eff    (busy_eff)
);

// File: verif/tb_exec_core.sv
`timescale 1ns/1ns

module tb_exec_core;

    localparam int NUM_TESTS      = 16;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 10 + 50;

    typedef struct {
        isa_pkg::op_e                    op;
        logic [core_pkg::REG_ADDR_W-1:0] rd;
        logic [core_pkg::REG_ADDR_W-1:0] rs1;
        logic [core_pkg::REG_ADDR_W-1:0] rs2;
        logic [core_pkg::IMM_W-1:0]      imm;
        logic                            use_imm;
        logic [core_pkg::XLEN-1:0]       result;
    } stim_t;

    typedef struct packed {
        logic [core_pkg::REG_ADDR_W-1:0] rd;
        logic [core_pkg::XLEN-1:0]       data;
    } wb_t;

    logic                            i_clk;
    logic                            i_rst_n;
    logic                            i_inst_valid;
    isa_pkg::op_e                    i_inst_op;
    logic [core_pkg::REG_ADDR_W-1:0] i_inst_rd;
    logic [core_pkg::REG_ADDR_W-1:0] i_inst_rs1;
    logic [core_pkg::REG_ADDR_W-1:0] i_inst_rs2;
    logic [core_pkg::IMM_W-1:0]      i_inst_imm;
    logic                            i_inst_use_imm;
    logic                            o_credit;
    logic                            o_credit_two;
    logic                            o_arith_wb_valid;
    logic [core_pkg::REG_ADDR_W-1:0] o_arith_wb_rd;
    logic [core_pkg::XLEN-1:0]       o_arith_wb_data;
    logic                            o_logic_wb_valid;
    logic [core_pkg::REG_ADDR_W-1:0] o_logic_wb_rd;
    logic [core_pkg::XLEN-1:0]       o_logic_wb_data;

    stim_t       stim [NUM_TESTS];
    wb_t         arith_expect [$];
    wb_t         logic_expect [$];
    logic [31:0] lcg_state = 32'h2adb;
    int          sent = 0;
    int          returned = 0;
    int          writebacks = 0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          cycles = 0;

    exec_core exec_core_inst (.*);

    always #4 i_clk = ~i_clk;

    // x1..x3 loaded first, x12 chain checks ordering, x0 write is dropped
    task automatic load_stimulus();
        stim[0]  = '{isa_pkg::OP_ADD,  5'd1,  5'd0,  5'd0, 32'h0000_1234, 1'b1, 64'h1234};
        stim[1]  = '{isa_pkg::OP_ADD,  5'd2,  5'd0,  5'd0, 32'hffff_fff0, 1'b1, -64'sd16};
        stim[2]  = '{isa_pkg::OP_ADD,  5'd3,  5'd0,  5'd0, 32'h0000_00ff, 1'b1, 64'hff};
        stim[3]  = '{isa_pkg::OP_SUB,  5'd4,  5'd1,  5'd3, 32'h0,         1'b0, 64'h1135};
        stim[4]  = '{isa_pkg::OP_SLT,  5'd5,  5'd2,  5'd1, 32'h0,         1'b0, 64'h1};
        stim[5]  = '{isa_pkg::OP_SLTU, 5'd6,  5'd2,  5'd1, 32'h0,         1'b0, 64'h0};
        stim[6]  = '{isa_pkg::OP_AND,  5'd7,  5'd1,  5'd3, 32'h0,         1'b0, 64'h34};
        stim[7]  = '{isa_pkg::OP_OR,   5'd8,  5'd1,  5'd0, 32'h0000_f000, 1'b1, 64'hf234};
        stim[8]  = '{isa_pkg::OP_XOR,  5'd9,  5'd2,  5'd3, 32'h0,         1'b0, -64'sd241};
        stim[9]  = '{isa_pkg::OP_SLL,  5'd10, 5'd3,  5'd0, 32'h0000_0044, 1'b1, 64'hff0};
        stim[10] = '{isa_pkg::OP_SLL,  5'd11, 5'd1,  5'd5, 32'h0,         1'b0, 64'h2468};
        stim[11] = '{isa_pkg::OP_ADD,  5'd12, 5'd11, 5'd0, 32'h0000_0001, 1'b1, 64'h2469};
        stim[12] = '{isa_pkg::OP_XOR,  5'd12, 5'd12, 5'd4, 32'h0,         1'b0, 64'h355c};
        stim[13] = '{isa_pkg::OP_SUB,  5'd13, 5'd12, 5'd10, 32'h0,        1'b0, 64'h256c};
        stim[14] = '{isa_pkg::OP_ADD,  5'd0,  5'd1,  5'd0, 32'h0000_0005, 1'b1, 64'h1239};
        stim[15] = '{isa_pkg::OP_OR,   5'd14, 5'd0,  5'd3, 32'h0,         1'b0, 64'hff};
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic isa_pkg::pipe_e pipe_for_op(input isa_pkg::op_e op);
        isa_pkg::pipe_e p;
        case (op)
            isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_SLT, isa_pkg::OP_SLTU:
                p = isa_pkg::PIPE_ARITH;
            default:
                p = isa_pkg::PIPE_LOGIC;
        endcase
        return p;
    endfunction

    function automatic int credits_held();
        return core_pkg::QUEUE_DEPTH - sent + returned;
    endfunction

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other; %0d of %0d writebacks seen",
                 mismatches, other_errors, writebacks, NUM_TESTS);
    endtask

    // one valid cycle, expected writeback goes to the queue of its pipe
    task automatic send_entry(input int n);
        wb_t exp;
        exp.rd         = stim[n].rd;
        exp.data       = stim[n].result;
        i_inst_valid   = 1'b1;
        i_inst_op      = stim[n].op;
        i_inst_rd      = stim[n].rd;
        i_inst_rs1     = stim[n].rs1;
        i_inst_rs2     = stim[n].rs2;
        i_inst_imm     = stim[n].imm;
        i_inst_use_imm = stim[n].use_imm;
        if (pipe_for_op(stim[n].op) == isa_pkg::PIPE_ARITH) begin
            arith_expect.push_back(exp);
        end else begin
            logic_expect.push_back(exp);
        end
        sent++;
        @(posedge i_clk);
        #1;
        i_inst_valid = 1'b0;
    endtask

    task automatic check_writeback(input isa_pkg::pipe_e pipe, input wb_t got);
        wb_t   exp;
        string name;
        name = (pipe == isa_pkg::PIPE_ARITH) ? "arith" : "logic";
        writebacks++;
        if ((pipe == isa_pkg::PIPE_ARITH) ? (arith_expect.size() == 0)
                                          : (logic_expect.size() == 0)) begin
            other_errors++;
            $display("unexpected writeback on the %s pipe to x%0d", name, got.rd);
        end else begin
            exp = (pipe == isa_pkg::PIPE_ARITH) ? arith_expect.pop_front()
                                                : logic_expect.pop_front();
            if (got != exp) begin
                mismatches++;
                $display("Mismatch at %0t: %s pipe wrote x%0d = %h, expected x%0d = %h",
                         $time, name, got.rd, got.data, exp.rd, exp.data);
            end
        end
    endtask

    // outputs are settled mid-cycle
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (o_credit) begin
                returned++;
            end
            if (o_credit_two) begin
                returned++;
            end
            if (o_credit_two && !o_credit) begin
                other_errors++;
                $display("second credit returned without the first one");
            end
            if (returned > sent) begin
                other_errors++;
                $display("more credits returned (%0d) than entries sent (%0d)", returned, sent);
            end
            if (o_arith_wb_valid) begin
                check_writeback(isa_pkg::PIPE_ARITH, '{o_arith_wb_rd, o_arith_wb_data});
            end
            if (o_logic_wb_valid) begin
                check_writeback(isa_pkg::PIPE_LOGIC, '{o_logic_wb_rd, o_logic_wb_data});
            end
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d writebacks still missing",
                     cycles, NUM_TESTS - writebacks);
            print_counts();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        int idle;
        i_clk          = 1'b0;
        i_rst_n        = 1'b0;
        i_inst_valid   = 1'b0;
        i_inst_op      = isa_pkg::OP_ADD;
        i_inst_rd      = '0;
        i_inst_rs1     = '0;
        i_inst_rs2     = '0;
        i_inst_imm     = '0;
        i_inst_use_imm = 1'b0;
        load_stimulus();
        repeat (2) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        for (int n = 0; n < NUM_TESTS; n++) begin
            idle = int'((next_random() >> 16) % 32'd3);
            repeat (idle) begin
                @(posedge i_clk);
                #1;
            end
            // hold off while no credit is left
            while (credits_held() == 0) begin
                @(posedge i_clk);
                #1;
            end
            send_entry(n);
        end
        while ((arith_expect.size() != 0) || (logic_expect.size() != 0)
               || (credits_held() != core_pkg::QUEUE_DEPTH)) begin
            @(posedge i_clk);
        end
        repeat (4) @(posedge i_clk);
        if (writebacks != NUM_TESTS) begin
            other_errors++;
            $display("saw %0d writebacks for %0d entries", writebacks, NUM_TESTS);
        end
        if (credits_held() != core_pkg::QUEUE_DEPTH) begin
            other_errors++;
            $display("sender ends with %0d credits instead of %0d",
                     credits_held(), core_pkg::QUEUE_DEPTH);
        end
        print_counts();
        if ((mismatches == 0) && (other_errors == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/core_pkg.sv
hdl/isa_pkg.sv
hdl/core_ifs.sv
hdl/issue_ctrl.sv
hdl/reg_file.sv
hdl/arith_unit.sv
hdl/logic_unit.sv
hdl/exec_core.sv
verif/exec_core_sva.sv
verif/tb_exec_core.sv

// File: run.sh
#!/bin/sh
# build with Verilator and look for the pass line in the simulation output
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_exec_core -f project.f \
    && ./obj_dir/Vtb_exec_core | grep "Simulation finished: PASS" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation failed"; exit 1; }
